// ==== hw/vgaPkg.sv ====
// ==========================================================
// Timing, geometry and address constants for the 1 bpp
// frame-buffer controller. Fixed 640x480 at 60 Hz on a 25 MHz
// pixel clock, 4x4 pixel upscale, word-aligned APB addressing
// ==========================================================

package vgaPkg;

    // ==========================================================
    // Horizontal timing, in pixel clocks
    // ==========================================================
    localparam int hDisplay = 640;
    localparam int hFront   = 16;
    localparam int hSyncLen = 96;
    localparam int hBack    = 48;
    // Full line, 800 clocks
    localparam int hTotal   = hDisplay + hFront + hSyncLen + hBack;

    // ==========================================================
    // Vertical timing, in lines
    // ==========================================================
    localparam int vDisplay = 480;
    localparam int vFront   = 10;
    localparam int vSyncLen = 2;
    localparam int vBack    = 33;
    // Full frame, 525 lines
    localparam int vTotal   = vDisplay + vFront + vSyncLen + vBack;

    // ==========================================================
    // Geometry and addressing
    // ==========================================================
    // Screen pixels per stored bit, both directions
    localparam int pixScale     = 4;
    // 160 logical pixels / 32 bits
    localparam int wordsPerLine = 5;
    // 120 logical lines x 5 words
    localparam int fbDepth      = 600;
    localparam int fbAddrW      = 10;
    localparam int apbAddrW     = 12;

    // One buffer word, seen as byte lanes on the CPU side
    // and as a 32-pixel span on the scan side
    typedef union packed {
        logic [3:0][7:0] bytes;
        // Bit n is the n-th pixel from the left
        logic [31:0]     pixels;
    } fbWordT;

endpackage

// ==== hw/vgaIfs.sv ====
// ==========================================================
// Internal links: buffer access port and raster timing bus
// wrEn and rdEn are mutually exclusive; rData one clock late
// ==========================================================

`timescale 1ns/1ps

// CPU-side access port of the frame buffer
interface fbWrIf import vgaPkg::*; ();

    logic               wrEn;
    logic               rdEn;
    logic [fbAddrW-1:0] addr;
    // Byte enables, one per lane
    logic [3:0]         strb;
    fbWordT             wData;
    // Valid the clock after rdEn
    fbWordT             rData;

    modport master (output wrEn, rdEn, addr, strb, wData, input rData);
    modport memory (input wrEn, rdEn, addr, strb, wData, output rData);

endinterface

// Raster position and syncs, all for the same clock
interface vgaTimingIf ();

    // Active low
    logic       hSyncN;
    logic       vSyncN;
    logic       inDisplay;
    logic [9:0] pixX;
    logic [9:0] pixY;

    modport source (output hSyncN, vSyncN, inDisplay, pixX, pixY);
    modport sink   (input hSyncN, vSyncN, inDisplay, pixX, pixY);

endinterface

// ==== hw/vgaSyncGen.sv ====
// ==========================================================
// Raster counters for 800x525 total, 640x480 visible
// Starts at pixel (0,0) on the first clock out of reset
// Outputs are combinational from the counters
// ==========================================================

`timescale 1ns/1ps

module vgaSyncGen import vgaPkg::*; (
    input logic        Clk25,
    input logic        arstN,
    vgaTimingIf.source timing
);

    logic [9:0] hCount;
    logic [9:0] vCount;
    logic       lineEnd;

    // Last pixel clock of the line
    assign lineEnd = (hCount == 10'(hTotal - 1));

    // ==========================================================
    // Counters
    // ==========================================================
    always_ff @(posedge Clk25 or negedge arstN) begin
        if (!arstN) begin
            hCount <= '0;
            vCount <= '0;
        end else begin
            if (lineEnd) begin
                hCount <= '0;
                // Line wrap moves down one line
                if (vCount == 10'(vTotal - 1)) begin
                    vCount <= '0;
                end else begin
                    vCount <= vCount + 10'd1;
                end
            end else begin
                hCount <= hCount + 10'd1;
            end
        end
    end

    // ==========================================================
    // Decode
    // ==========================================================
    // Sync pulse sits after display plus front porch
    assign timing.hSyncN = !((hCount >= 10'(hDisplay + hFront)) &&
                             (hCount <  10'(hDisplay + hFront + hSyncLen)));
    assign timing.vSyncN = !((vCount >= 10'(vDisplay + vFront)) &&
                             (vCount <  10'(vDisplay + vFront + vSyncLen)));

    assign timing.inDisplay = (hCount < 10'(hDisplay)) && (vCount < 10'(vDisplay));
    assign timing.pixX      = hCount;
    assign timing.pixY      = vCount;

    // Line counter never runs past the wrap point
    hCountRange: assert property (@(posedge Clk25) disable iff (!arstN)
        hCount < 10'(hTotal));

endmodule

// ==== hw/apbFbSlave.sv ====
// ==========================================================
// APB3 slave onto the frame buffer with PSTRB on writes
// Word-aligned addresses only and PADDR[1:0] ignored
// Writes and errors complete with no wait state
// Reads take one wait state
// ==========================================================

`timescale 1ns/1ps

module apbFbSlave import vgaPkg::*; (
    input  logic                Clk25,
    input  logic                arstN,
    input  logic                PSEL,
    input  logic                PENABLE,
    input  logic                PWRITE,
    input  logic [apbAddrW-1:0] PADDR,
    input  logic [31:0]         PWDATA,
    input  logic [3:0]          PSTRB,
    output logic [31:0]         PRDATA,
    output logic                PREADY,
    output logic                PSLVERR,
    fbWrIf.master               wr
);

    logic setupPhase;
    logic addrOk;
    logic rdPend;

    // ==========================================================
    // Decode
    // ==========================================================
    // Setup cycle of a transfer
    assign setupPhase = PSEL && !PENABLE;
    // Inside the 600-word window
    assign addrOk = (PADDR < apbAddrW'(4 * fbDepth));

    // Byte address to word index
    assign wr.addr  = PADDR[apbAddrW-1:2];
    assign wr.strb  = PSTRB;
    assign wr.wData = PWDATA;

    // Memory strobes fire once at the end of setup
    assign wr.wrEn = setupPhase && PWRITE && addrOk;
    assign wr.rdEn = setupPhase && !PWRITE && addrOk;

    // ==========================================================
    // Response
    // ==========================================================
    always_ff @(posedge Clk25 or negedge arstN) begin
        if (!arstN) begin
            rdPend  <= 1'b0;
            PREADY  <= 1'b0;
            PSLVERR <= 1'b0;
            PRDATA  <= '0;
        end else begin
            // Response lasts one clock
            PREADY  <= 1'b0;
            PSLVERR <= 1'b0;
            rdPend  <= 1'b0;
            if (rdPend) begin
                // Memory data is back so finish the read
                PREADY <= 1'b1;
                PRDATA <= wr.rData;
            end else if (setupPhase) begin
                if (wr.rdEn) begin
                    // Wait for the buffer
                    rdPend <= 1'b1;
                end else begin
                    // Write or bad address finishes in first access cycle
                    PREADY  <= 1'b1;
                    PSLVERR <= !addrOk;
                    PRDATA  <= '0;
                end
            end
        end
    end

    // Bus protocol from the master side
    penableNeedsPsel: assert property (@(posedge Clk25) disable iff (!arstN)
        PENABLE |-> PSEL);

endmodule

// ==== hw/frameBuffer.sv ====
// ==========================================================
// 600 x 32 frame buffer, one bit per logical pixel
// Port A: byte-strobed write or word read. Port B: scan read
// Both reads one clock latency, no contents reset
// ==========================================================

`timescale 1ns/1ps

module frameBuffer import vgaPkg::*; (
    input  logic               Clk25,
    fbWrIf.memory              wr,
    input  logic [fbAddrW-1:0] scanAddr,
    output fbWordT             scanData
);

    fbWordT mem [fbDepth];

    // ==========================================================
    // Port A, CPU side
    // ==========================================================
    always_ff @(posedge Clk25) begin
        if (wr.wrEn) begin
            // Only enabled lanes change
            for (int lane = 0; lane < 4; lane++) begin
                if (wr.strb[lane]) begin
                    mem[wr.addr].bytes[lane] <= wr.wData.bytes[lane];
                end
            end
        end
        if (wr.rdEn) begin
            wr.rData <= mem[wr.addr];
        end
    end

    // ==========================================================
    // Port B, scan side
    // ==========================================================
    // Read every clock
    always_ff @(posedge Clk25) begin
        scanData <= mem[scanAddr];
    end

    // Slave never issues both strobes at once
    wrRdExclusive: assert property (@(posedge Clk25)
        !(wr.wrEn && wr.rdEn));

    // Slave filters bad addresses before the memory
    portAddrRange: assert property (@(posedge Clk25)
        (wr.wrEn || wr.rdEn) |-> (wr.addr < fbAddrW'(fbDepth)));

    // Fetch only addresses while on the visible area
    scanAddrRange: assert property (@(posedge Clk25)
        scanAddr < fbAddrW'(fbDepth));

endmodule

// ==== hw/pixelFetchCtrl.sv ====
// ==========================================================
// Scan-side fetch: raster position to buffer word and bit
// Outputs lag the timing bus by exactly 2 clocks, with sync
// and colour kept aligned. Blanking forces colour to zero
// ==========================================================

`timescale 1ns/1ps

module pixelFetchCtrl import vgaPkg::*; (
    input  logic               Clk25,
    input  logic               arstN,
    vgaTimingIf.sink           timing,
    output logic [fbAddrW-1:0] scanAddr,
    input  fbWordT             scanData,
    output logic [3:0]         red,
    output logic [3:0]         green,
    output logic [3:0]         blue,
    output logic               hSync,
    output logic               vSync
);

    logic [4:0] bitSel;
    logic [4:0] bitSelQ;
    logic       dispQ;
    logic       hSyncQ;
    logic       vSyncQ;
    logic       pixBit;
    logic [3:0] pixColour;

    // ==========================================================
    // Address generation
    // ==========================================================
    // Row of words times line pitch, plus 128-pixel span index
    // Held at word 0 during blanking
    assign scanAddr = timing.inDisplay ?
                      fbAddrW'((timing.pixY / pixScale) * wordsPerLine +
                               timing.pixX / (32 * pixScale)) :
                      '0;

    // Pixel within the word
    assign bitSel = 5'((timing.pixX / pixScale) % 32);

    // ==========================================================
    // Stage 1, lined up with scanData
    // ==========================================================
    always_ff @(posedge Clk25 or negedge arstN) begin
        if (!arstN) begin
            dispQ  <= 1'b0;
            hSyncQ <= 1'b1;
            vSyncQ <= 1'b1;
        end else begin
            dispQ  <= timing.inDisplay;
            hSyncQ <= timing.hSyncN;
            vSyncQ <= timing.vSyncN;
        end
    end

    // Bit select travels with the data
    always_ff @(posedge Clk25) begin
        bitSelQ <= bitSel;
    end

    // Pick the pixel through the scan view
    assign pixBit = scanData.pixels[bitSelQ];
    // Replicated to full intensity, black while blanking
    assign pixColour = dispQ ? {4{pixBit}} : 4'b0000;

    // ==========================================================
    // Stage 2, output registers
    // ==========================================================
    always_ff @(posedge Clk25 or negedge arstN) begin
        if (!arstN) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
            hSync <= 1'b1;
            vSync <= 1'b1;
        end else begin
            red   <= pixColour;
            green <= pixColour;
            blue  <= pixColour;
            hSync <= hSyncQ;
            vSync <= vSyncQ;
        end
    end

    // No light outside the visible area
    blankIsBlack: assert property (@(posedge Clk25) disable iff (!arstN)
        !dispQ |=> (red == '0) && (green == '0) && (blue == '0));

endmodule

// ==== hw/vgaCtrlTop.sv ====
// ==========================================================
// Monochrome VGA frame-buffer controller, APB3 CPU port
// Single 25 MHz clock for bus and video, no CDC
// Video path has no back-pressure
// ==========================================================

`timescale 1ns/1ps

module vgaCtrlTop import vgaPkg::*; (
    input  logic                Clk25,
    input  logic                arstN,
    // APB
    input  logic                PSEL,
    input  logic                PENABLE,
    input  logic                PWRITE,
    input  logic [apbAddrW-1:0] PADDR,
    input  logic [31:0]         PWDATA,
    input  logic [3:0]          PSTRB,
    output logic [31:0]         PRDATA,
    output logic                PREADY,
    output logic                PSLVERR,
    // VGA, syncs active low
    output logic [3:0]          red,
    output logic [3:0]          green,
    output logic [3:0]          blue,
    output logic                hSync,
    output logic                vSync
);

    logic [fbAddrW-1:0] scanAddr;
    fbWordT             scanData;

    fbWrIf      fbWr0 ();
    vgaTimingIf timing0 ();

    // ==========================================================
    // Blocks
    // ==========================================================
    vgaSyncGen syncGen0 (
        .Clk25  (Clk25),
        .arstN  (arstN),
        .timing (timing0.source)
    );

    apbFbSlave apbSlave0 (
        .Clk25   (Clk25),
        .arstN   (arstN),
        .PSEL    (PSEL),
        .PENABLE (PENABLE),
        .PWRITE  (PWRITE),
        .PADDR   (PADDR),
        .PWDATA  (PWDATA),
        .PSTRB   (PSTRB),
        .PRDATA  (PRDATA),
        .PREADY  (PREADY),
        .PSLVERR (PSLVERR),
        .wr      (fbWr0.master)
    );

    frameBuffer fb0 (
        .Clk25    (Clk25),
        .wr       (fbWr0.memory),
        .scanAddr (scanAddr),
        .scanData (scanData)
    );

    pixelFetchCtrl fetch0 (
        .Clk25    (Clk25),
        .arstN    (arstN),
        .timing   (timing0.sink),
        .scanAddr (scanAddr),
        .scanData (scanData),
        .red      (red),
        .green    (green),
        .blue     (blue),
        .hSync    (hSync),
        .vSync    (vSync)
    );

endmodule

// ==== dv/clkGen.sv ====
// ==========================================================
// Testbench clock and reset source
// 100 ns clock period, reset low for the first 5 cycles
// Reset is released on a falling edge
// ==========================================================

`timescale 1ns/1ps

module clkGen (
    output logic Clk25,
    output logic arstN
);

    // Half period of 50 ns
    initial begin
        Clk25 = 1'b0;
        forever #50 Clk25 = ~Clk25;
    end

    initial begin
        arstN = 1'b0;
        repeat (5) @(posedge Clk25);
        @(negedge Clk25);
        arstN = 1'b1;
    end

endmodule

// ==== dv/vgaTb.sv ====
// ==========================================================
// Testbench for the VGA frame-buffer controller
// Inputs change on the falling edge and outputs are sampled there too
// Image check covers one full frame after the first vSync
// Run is bounded to three frames of clocks
// ==========================================================

`timescale 1ns/1ps

module vgaTb import vgaPkg::*; ();

    logic                Clk25;
    logic                arstN;
    logic                PSEL;
    logic                PENABLE;
    logic                PWRITE;
    logic [apbAddrW-1:0] PADDR;
    logic [31:0]         PWDATA;
    logic [3:0]          PSTRB;
    logic [31:0]         PRDATA;
    logic                PREADY;
    logic                PSLVERR;
    logic [3:0]          red;
    logic [3:0]          green;
    logic [3:0]          blue;
    logic                hSync;
    logic                vSync;

    // Expected buffer contents
    logic [31:0] model [fbDepth];
    integer      seed;
    int          valueErrs = 0;
    int          otherErrs = 0;
    int          cycleCount = 0;
    int          vPeriodChecks = 0;
    bit          imageDone = 1'b0;

    clkGen clkGen0 (.Clk25(Clk25), .arstN(arstN));

    vgaCtrlTop dut0 (
        .Clk25(Clk25), .arstN(arstN),
        .PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE), .PADDR(PADDR),
        .PWDATA(PWDATA), .PSTRB(PSTRB), .PRDATA(PRDATA), .PREADY(PREADY),
        .PSLVERR(PSLVERR),
        .red(red), .green(green), .blue(blue), .hSync(hSync), .vSync(vSync)
    );

    // ==========================================================
    // Helpers
    // ==========================================================
    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            valueErrs++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic reportProblem(input string what);
        otherErrs++;
        $display("ERROR: %s", what);
    endtask

    task automatic printSummary();
        $display("Errors: %0d value mismatches, %0d other failures", valueErrs, otherErrs);
    endtask

    task automatic checkResetState(input string name);
        checkValue({name, " colours"}, 32'h0, {red, green, blue});
        checkValue({name, " syncs"}, 32'h3, {hSync, vSync});
        checkValue({name, " PREADY/PSLVERR"}, 32'h0, {PREADY, PSLVERR});
    endtask

    // Byte lanes with a set strobe take the new data
    function automatic logic [31:0] mergeBytes(input logic [31:0] old,
                                               input logic [31:0] data,
                                               input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int lane = 0; lane < 4; lane++) begin
            if (strb[lane]) res[8*lane +: 8] = data[8*lane +: 8];
        end
        return res;
    endfunction

    // Expected colour of a visible screen pixel
    function automatic logic [3:0] refColour(input int x, input int y);
        int word;
        int bitIdx;
        word   = (y / pixScale) * wordsPerLine + x / (32 * pixScale);
        bitIdx = (x / pixScale) % 32;
        return model[word][bitIdx] ? 4'hF : 4'h0;
    endfunction

    // One APB transfer with setup then access until PREADY
    task automatic apbAccess(input bit write, input logic [apbAddrW-1:0] addr,
                             input logic [31:0] data, input logic [3:0] strb,
                             output logic [31:0] rdata, output logic err,
                             output int waits);
        @(negedge Clk25);
        PSEL    = 1'b1;
        PENABLE = 1'b0;
        PWRITE  = write;
        PADDR   = addr;
        PWDATA  = data;
        PSTRB   = strb;
        @(negedge Clk25);
        PENABLE = 1'b1;
        waits   = 0;
        while (!PREADY && waits < 8) begin
            @(negedge Clk25);
            waits++;
        end
        assert (PREADY === 1'b1) else reportProblem("PREADY never rose on an APB access");
        rdata = PRDATA;
        err   = PSLVERR;
        // Transfer completes on the next rising edge
        @(negedge Clk25);
        PSEL    = 1'b0;
        PENABLE = 1'b0;
    endtask

    // ==========================================================
    // Watchdog
    // ==========================================================
    always @(posedge Clk25) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= 3 * vTotal * hTotal) begin
            otherErrs++;
            $display("ERROR: run timed out after %0d cycles", cycleCount);
            printSummary();
            $display("TEST FAIL");
            $finish;
        end
    end

    // ==========================================================
    // Sync width and period monitor
    // ==========================================================
    initial begin : syncCheck
        int   hSince;
        int   hLow;
        int   vSince;
        int   vLow;
        bit   hSeen;
        bit   vSeen;
        logic hPrev;
        logic vPrev;
        hSince = 0;
        hLow   = 0;
        vSince = 0;
        vLow   = 0;
        hSeen  = 1'b0;
        vSeen  = 1'b0;
        hPrev  = 1'b1;
        vPrev  = 1'b1;
        wait (arstN === 1'b1);
        forever begin
            @(negedge Clk25);
            hSince++;
            vSince++;
            // Falling edge starts a pulse and closes a period
            if (hPrev && !hSync) begin
                if (hSeen) checkValue("hSync period", hTotal, hSince);
                hSeen  = 1'b1;
                hSince = 0;
                hLow   = 0;
            end
            if (!hSync) hLow++;
            if (!hPrev && hSync && hSeen) checkValue("hSync width", hSyncLen, hLow);
            hPrev = hSync;
            if (vPrev && !vSync) begin
                if (vSeen) begin
                    checkValue("vSync period", vTotal * hTotal, vSince);
                    vPeriodChecks++;
                end
                vSeen  = 1'b1;
                vSince = 0;
                vLow   = 0;
            end
            if (!vSync) vLow++;
            if (!vPrev && vSync && vSeen) checkValue("vSync width", vSyncLen * hTotal, vLow);
            vPrev = vSync;
        end
    end

    // ==========================================================
    // Image monitor over one full frame
    // ==========================================================
    initial begin : imageCheck
        logic       vPrev;
        bit         found;
        int         x;
        int         y;
        logic [3:0] expected;
        vPrev = 1'b1;
        found = 1'b0;
        wait (arstN === 1'b1);
        while (!found) begin
            @(negedge Clk25);
            found = vPrev && !vSync;
            vPrev = vSync;
        end
        // vSync falls on pixel 0 of line vDisplay + vFront
        repeat ((vSyncLen + vBack) * hTotal) @(negedge Clk25);
        for (int n = 0; n < vTotal * hTotal; n++) begin
            x = n % hTotal;
            y = n / hTotal;
            expected = (x < hDisplay && y < vDisplay) ? refColour(x, y) : 4'h0;
            assert ({red, green, blue} === {3{expected}}) else begin
                valueErrs++;
                $display("CHECK FAILED image (%0d,%0d): expected %h, actual %h",
                         x, y, {3{expected}}, {red, green, blue});
            end
            @(negedge Clk25);
        end
        imageDone = 1'b1;
    end

    // ==========================================================
    // Main sequence
    // ==========================================================
    initial begin : mainFlow
        logic [31:0]         rdata;
        logic [31:0]         data;
        logic [3:0]          strb;
        logic [apbAddrW-1:0] addr;
        logic                err;
        int                  waits;
        int                  idx;
        seed    = 58;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
        PWRITE  = 1'b0;
        PADDR   = '0;
        PWDATA  = '0;
        PSTRB   = '0;

        // Reset values during and just after reset
        @(negedge Clk25);
        checkResetState("reset active");
        wait (arstN === 1'b1);
        checkResetState("reset released");
        @(negedge Clk25);
        checkResetState("first cycle after reset");

        // Random image in full words
        for (int i = 0; i < fbDepth; i++) begin
            data     = $random(seed);
            model[i] = data;
            apbAccess(1'b1, apbAddrW'(4 * i), data, 4'hF, rdata, err, waits);
            checkValue("fill wait states", 0, waits);
            checkValue("fill PSLVERR", 0, err);
        end
        // Buffer stays untouched while the frame is scanned
        wait (imageDone);

        // Partial writes with read-back
        repeat (64) begin
            idx  = ($random(seed) & 32'h7fffffff) % fbDepth;
            data = $random(seed);
            strb = 4'($random(seed));
            apbAccess(1'b1, apbAddrW'(4 * idx), data, strb, rdata, err, waits);
            model[idx] = mergeBytes(model[idx], data, strb);
            checkValue("strobe write wait states", 0, waits);
            apbAccess(1'b0, apbAddrW'(4 * idx), 32'h0, 4'h0, rdata, err, waits);
            checkValue("strobe read-back", model[idx], rdata);
            checkValue("read wait states", 1, waits);
            checkValue("strobe read PSLVERR", 0, err);
        end

        // Out-of-range accesses to words fbDepth..1023
        repeat (16) begin
            idx  = fbDepth + ($random(seed) & 32'h7fffffff) % (1024 - fbDepth);
            addr = apbAddrW'(4 * idx);
            data = $random(seed);
            apbAccess(1'b1, addr, data, 4'hF, rdata, err, waits);
            checkValue("bad write PSLVERR", 1, err);
            checkValue("bad write wait states", 0, waits);
            apbAccess(1'b0, addr, 32'h0, 4'h0, rdata, err, waits);
            checkValue("bad read PSLVERR", 1, err);
            checkValue("bad read wait states", 0, waits);
            checkValue("bad read PRDATA", 0, rdata);
        end

        // Whole buffer against the model
        for (int i = 0; i < fbDepth; i++) begin
            apbAccess(1'b0, apbAddrW'(4 * i), 32'h0, 4'h0, rdata, err, waits);
            checkValue("final read-back", model[i], rdata);
            checkValue("final read wait states", 1, waits);
        end

        assert (vPeriodChecks > 0) else reportProblem("no full vSync period was seen");
        printSummary();
        if (valueErrs + otherErrs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== all.f ====
hw/vgaPkg.sv
hw/vgaIfs.sv
hw/vgaSyncGen.sv
hw/apbFbSlave.sv
hw/frameBuffer.sv
hw/pixelFetchCtrl.sv
hw/vgaCtrlTop.sv
dv/clkGen.sv
dv/vgaTb.sv
